//--- verilog/color_pkg.sv
// **************************************************
// colour tracking shared definitions
// QQVGA frame geometry, inner window, histogram and
// result constants plus the payload types
// **************************************************

package color_pkg;

  // source frame, 160x120 with 12-bit rgb 4:4:4
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows; // 19200
  localparam int addr_w   = 15;
  localparam int col_w    = 8;
  localparam int row_w    = 7;
  localparam int pxl_w    = 12;

  // colour msb of each component inside a pixel
  localparam int msb_red   = 11;
  localparam int msb_green = 7;
  localparam int msb_blue  = 3;

  // inner window, 128 columns by 104 rows
  localparam int inner_col_first = 16;
  localparam int inner_col_last  = 143;
  localparam int inner_row_first = 8;
  localparam int inner_row_last  = 111;
  localparam int inner_pxls      = (inner_col_last - inner_col_first + 1) *
                                   (inner_row_last - inner_row_first + 1); // 13312

  // column histogram
  localparam int hist_bins   = 8;
  localparam int hist_bin_w  = $clog2(hist_bins);
  localparam int bin_cols    = 16;  // window columns per bin
  localparam int hist_val_w  = 11;  // up to 16*104 = 1664
  localparam int inner_cnt_w = 14;  // up to 13312

  // result stage
  localparam int min_color_pxls = 128; // noise floor
  localparam int mid_shift      = 4;   // middle tolerance is total/16
  localparam int centroid_w     = 8;   // one led per bin
  localparam int prox_w         = 3;

  typedef logic [pxl_w-1:0]       pixel_t;
  typedef logic [addr_w-1:0]      pxl_addr_t;
  typedef logic [2:0]             filter_t;    // {red, green, blue}
  typedef logic [hist_bin_w-1:0]  hist_bin_t;
  typedef logic [hist_val_w-1:0]  bin_cnt_t;
  typedef logic [inner_cnt_w-1:0] inner_cnt_t;
  typedef logic [centroid_w-1:0]  centroid_t;
  typedef logic [prox_w-1:0]      prox_t;

endpackage

//--- verilog/frame_scan.sv
// **************************************************
// frame scanner
// raster address generator for the source memory,
// pixel tags aligned with the returning read data
// **************************************************

`timescale 1ns/10ps

module frame_scan import color_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output pxl_addr_t orig_addr,
  output pxl_addr_t proc_addr,
  output logic      proc_we,
  output logic      pxl_inner,
  output hist_bin_t pxl_bin,
  output logic      frame_done
);

  pxl_addr_t        cnt_pxl;       // read address
  logic [col_w-1:0] col, col_d;    // col_d follows orig_pxl
  logic [row_w-1:0] row, row_d;
  logic [col_w-1:0] win_col;       // column relative to window start
  logic             end_frame;
  logic             end_ln;

  assign end_frame = (cnt_pxl == pxl_addr_t'(img_pxls - 1));
  assign end_ln    = (col == col_w'(img_cols - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_pxl    <= '0;
      proc_addr  <= '0;
      proc_we    <= 1'b0;
      col        <= '0;
      row        <= '0;
      col_d      <= '0;
      row_d      <= '0;
      frame_done <= 1'b0;
    end else begin
      proc_we   <= 1'b1;
      proc_addr <= cnt_pxl;            // memory returns data one cycle later
      cnt_pxl   <= end_frame ? '0 : cnt_pxl + 1'b1;
      col       <= end_ln ? '0 : col + 1'b1;
      if (end_ln) begin
        row <= (row == row_w'(img_rows - 1)) ? '0 : row + 1'b1;
      end
      col_d      <= col;
      row_d      <= row;
      frame_done <= (cnt_pxl == '0);   // pixel 0 is on orig_pxl next cycle
    end
  end

  assign orig_addr = cnt_pxl;

  // window and bin tags on the delayed position
  assign pxl_inner = (col_d >= inner_col_first) && (col_d <= inner_col_last) &&
                     (row_d >= inner_row_first) && (row_d <= inner_row_last);

  assign win_col = col_d - col_w'(inner_col_first); // junk outside window, unused then
  assign pxl_bin = hist_bin_t'(win_col / bin_cols);

  // frame end is a single-cycle strobe, 19200 cycles apart
  a_frame_done_pulse : assert property (
    @(posedge clk) disable iff (rst) frame_done |=> !frame_done
  );

endmodule

//--- verilog/color_decode.sv
// **************************************************
// colour decoder
// button driven filter selection and per-pixel
// colour match, non-matching pixels go black
// **************************************************

`timescale 1ns/10ps

module color_decode import color_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    proc_ctrl,
  input  pixel_t  orig_pxl,
  output filter_t rgbfilter,
  output logic    pxl_hit,
  output pixel_t  proc_pxl
);

  logic    ctrl_rg1, ctrl_rg2; // button synchroniser
  logic    ctrl_rise;
  filter_t pxl_msbs;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_rg1 <= 1'b0;
      ctrl_rg2 <= 1'b0;
    end else begin
      ctrl_rg1 <= proc_ctrl;
      ctrl_rg2 <= ctrl_rg1;
    end
  end

  assign ctrl_rise = ctrl_rg1 & ~ctrl_rg2; // one pulse per press

  // filter cycle: none, r, g, b, yellow, magenta, cyan, white
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rgbfilter <= 3'b000;
    end else if (ctrl_rise) begin
      case (rgbfilter)
        3'b000:  rgbfilter <= 3'b100; // red
        3'b100:  rgbfilter <= 3'b010; // green
        3'b010:  rgbfilter <= 3'b001; // blue
        3'b001:  rgbfilter <= 3'b110; // yellow
        3'b110:  rgbfilter <= 3'b101; // magenta
        3'b101:  rgbfilter <= 3'b011; // cyan
        3'b011:  rgbfilter <= 3'b111; // white
        default: rgbfilter <= 3'b000; // back to no filter
      endcase
    end
  end

  // a pixel matches when its colour msbs equal the filter code
  assign pxl_msbs = {orig_pxl[msb_red], orig_pxl[msb_green], orig_pxl[msb_blue]};
  assign pxl_hit  = (rgbfilter == 3'b000) || (pxl_msbs == rgbfilter);

  assign proc_pxl = pxl_hit ? orig_pxl : '0; // black when filtered out

  a_black_on_miss : assert property (
    @(posedge clk) disable iff (rst) !pxl_hit |-> (proc_pxl == '0)
  );

endmodule

//--- verilog/histogram_acc.sv
// **************************************************
// column histogram accumulator
// counts matching pixels per bin and in total over
// the inner window, restarted at every frame end
// **************************************************

`timescale 1ns/10ps

module histogram_acc import color_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pxl_inner,
  input  logic                       pxl_hit,
  input  logic                       frame_done,
  input  hist_bin_t                  pxl_bin,
  output bin_cnt_t [hist_bins-1:0]   frame_bins,
  output inner_cnt_t                 frame_total
);

  logic count_en;  // matching pixel inside the window

  assign count_en = pxl_inner & pxl_hit;

  // outputs are the live counters, so in the frame_done cycle they still
  // hold the finished frame, the result block latches them then
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_bins  <= '0;
      frame_total <= '0;
    end else begin
      for (int i = 0; i < hist_bins; i++) begin
        if (frame_done) begin
          // restart from the current pixel
          frame_bins[i] <= bin_cnt_t'(count_en && (pxl_bin == hist_bin_t'(i)));
        end else if (count_en && (pxl_bin == hist_bin_t'(i))) begin
          frame_bins[i] <= frame_bins[i] + 1'b1;
        end
      end
      if (frame_done) begin
        frame_total <= inner_cnt_t'(count_en);
      end else if (count_en) begin
        frame_total <= frame_total + 1'b1;
      end
    end
  end

  // a frame can never hold more hits than window pixels
  a_total_range : assert property (
    @(posedge clk) disable iff (rst) frame_total <= inner_cnt_t'(inner_pxls)
  );

endmodule

//--- verilog/centroid_result.sv
// **************************************************
// centroid and proximity result
// turns the finished histogram into a led centroid
// and a proximity level, latched at frame end
// **************************************************

`timescale 1ns/10ps

module centroid_result import color_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     frame_done,
  input  bin_cnt_t [hist_bins-1:0] frame_bins,
  input  inner_cnt_t               frame_total,
  output centroid_t                centroid,
  output prox_t                    proximity,
  output logic                     new_centroid
);

  inner_cnt_t sum_01, sum_012, sum_left;   // from the left edge
  inner_cnt_t sum_67, sum_567, sum_rght;   // from the right edge
  inner_cnt_t total_half;
  inner_cnt_t mid_tol;                     // left/right balance tolerance
  inner_cnt_t abs_diff;
  logic       more_left;
  centroid_t  centroid_nxt;
  prox_t      prox_nxt;

  // partial sums of the bins
  always_comb begin
    sum_01   = inner_cnt_t'(frame_bins[0]) + inner_cnt_t'(frame_bins[1]);
    sum_012  = sum_01 + inner_cnt_t'(frame_bins[2]);
    sum_left = sum_012 + inner_cnt_t'(frame_bins[3]);
    sum_67   = inner_cnt_t'(frame_bins[7]) + inner_cnt_t'(frame_bins[6]);
    sum_567  = sum_67 + inner_cnt_t'(frame_bins[5]);
    sum_rght = sum_567 + inner_cnt_t'(frame_bins[4]);
  end

  assign total_half = frame_total >> 1;
  assign mid_tol    = frame_total >> mid_shift;
  assign more_left  = (sum_left > sum_rght);
  assign abs_diff   = more_left ? (sum_left - sum_rght) : (sum_rght - sum_left);

  // centroid, checked from the outer edge towards the middle
  always_comb begin
    centroid_nxt = '0;
    if (frame_total <= inner_cnt_t'(min_color_pxls)) begin
      centroid_nxt = '0;                  // noise only
    end else if (abs_diff < mid_tol) begin
      centroid_nxt[4:3] = 2'b11;          // middle
    end else if (more_left) begin
      if (inner_cnt_t'(frame_bins[0]) >= total_half)
        centroid_nxt[0] = 1'b1;
      else if (sum_01 >= total_half)
        centroid_nxt[1] = 1'b1;
      else if (sum_012 >= total_half)
        centroid_nxt[2] = 1'b1;
      else if (sum_left > total_half)
        centroid_nxt[3] = 1'b1;
    end else begin
      if (inner_cnt_t'(frame_bins[7]) >= total_half)
        centroid_nxt[7] = 1'b1;
      else if (sum_67 >= total_half)
        centroid_nxt[6] = 1'b1;
      else if (sum_567 >= total_half)
        centroid_nxt[5] = 1'b1;
      else if (sum_rght > total_half)
        centroid_nxt[4] = 1'b1;
    end
  end

  // proximity from the amount of colour seen, 7 is close
  always_comb begin
    if (frame_total >= inner_cnt_t'(6144))                prox_nxt = 3'd7;
    else if (frame_total >= inner_cnt_t'(4096))           prox_nxt = 3'd6;
    else if (frame_total >= inner_cnt_t'(2048))           prox_nxt = 3'd5;
    else if (frame_total >= inner_cnt_t'(1024))           prox_nxt = 3'd4;
    else if (frame_total >= inner_cnt_t'(512))            prox_nxt = 3'd3;
    else if (frame_total >= inner_cnt_t'(256))            prox_nxt = 3'd2;
    else if (frame_total >= inner_cnt_t'(min_color_pxls)) prox_nxt = 3'd1;
    else                                                  prox_nxt = 3'd0;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      centroid     <= '0;
      proximity    <= '0;
      new_centroid <= 1'b0;
    end else begin
      new_centroid <= frame_done;   // strobe the cycle after frame end
      if (frame_done) begin
        centroid  <= centroid_nxt;
        proximity <= prox_nxt;
      end
    end
  end

  a_centroid_hot : assert property (
    @(posedge clk) disable iff (rst) $countones(centroid) <= 2
  );

endmodule

//--- verilog/color_proc_top.sv
// **************************************************
// colour tracking top level
// scanner, colour decoder, histogram and result
// stage connected into one pipeline
// **************************************************

`timescale 1ns/10ps

module color_proc_top import color_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      proc_ctrl,     // filter select button
  input  pixel_t    orig_pxl,      // source pixel, one cycle after orig_addr
  output pxl_addr_t orig_addr,
  output logic      proc_we,
  output pxl_addr_t proc_addr,
  output pixel_t    proc_pxl,
  output centroid_t centroid,
  output logic      new_centroid,
  output prox_t     proximity,
  output filter_t   rgbfilter
);

  logic                     pxl_inner;
  hist_bin_t                pxl_bin;
  logic                     frame_done;
  logic                     pxl_hit;
  bin_cnt_t [hist_bins-1:0] frame_bins;
  inner_cnt_t               frame_total;

  frame_scan scan_i (
    .clk        (clk),
    .rst        (rst),
    .orig_addr  (orig_addr),
    .proc_addr  (proc_addr),
    .proc_we    (proc_we),
    .pxl_inner  (pxl_inner),
    .pxl_bin    (pxl_bin),
    .frame_done (frame_done)
  );

  color_decode decode_i (
    .clk       (clk),
    .rst       (rst),
    .proc_ctrl (proc_ctrl),
    .orig_pxl  (orig_pxl),
    .rgbfilter (rgbfilter),
    .pxl_hit   (pxl_hit),
    .proc_pxl  (proc_pxl)
  );

  histogram_acc hist_i (
    .clk         (clk),
    .rst         (rst),
    .pxl_inner   (pxl_inner),
    .pxl_hit     (pxl_hit),
    .frame_done  (frame_done),
    .pxl_bin     (pxl_bin),
    .frame_bins  (frame_bins),
    .frame_total (frame_total)
  );

  centroid_result result_i (
    .clk          (clk),
    .rst          (rst),
    .frame_done   (frame_done),
    .frame_bins   (frame_bins),
    .frame_total  (frame_total),
    .centroid     (centroid),
    .proximity    (proximity),
    .new_centroid (new_centroid)
  );

endmodule

//--- sim/tb_clock_gen.sv
// **************************************************
// testbench clock and reset
// free running clock, reset held for a few cycles
// **************************************************

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns  = 4,
  parameter int rst_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release just after a rising edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- sim/color_proc_tb.sv
// **************************************************
// colour tracking testbench
// models the source frame memory, replays the scene
// trace and checks pixels, filter and frame results
// **************************************************

`timescale 1ns/10ps

module color_proc_tb import color_pkg::*; ();

  localparam int clk_period = 4;
  localparam int press_hold = 4;   // cycles per button level

  logic      clk;
  logic      rst;
  logic      proc_ctrl;
  pixel_t    orig_pxl;
  pxl_addr_t orig_addr;
  pxl_addr_t proc_addr;
  logic      proc_we;
  pixel_t    proc_pxl;
  centroid_t centroid;
  logic      new_centroid;
  prox_t     proximity;
  filter_t   rgbfilter;

  // scene is one rectangle on a plain background, empty at start
  pixel_t rect_rgb = '0;
  pixel_t bg_rgb   = '0;
  int     rect_c0  = 1;
  int     rect_c1  = 0;
  int     rect_r0  = 1;
  int     rect_r1  = 0;

  int        t_press[$], t_c0[$], t_c1[$], t_r0[$], t_r1[$], t_prox[$];
  pixel_t    t_rgb[$], t_bg[$];
  centroid_t t_cent[$];

  int        filter_idx  = 0;      // position in the filter cycle
  filter_t   exp_filter  = 3'b000;
  logic      settling    = 1'b0;   // scene or filter in transition, pixels unchecked
  pxl_addr_t exp_addr    = '0;
  int        err_cnt     = 0;
  int        cyc         = 0;
  int        last_strobe = -1;
  logic      trace_ready = 1'b0;
  pixel_t    rd_data;

  tb_clock_gen #(.period_ns(clk_period), .rst_cycles(2)) clk_gen_i (.clk(clk), .rst(rst));

  color_proc_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .proc_ctrl    (proc_ctrl),
    .orig_pxl     (orig_pxl),
    .orig_addr    (orig_addr),
    .proc_we      (proc_we),
    .proc_addr    (proc_addr),
    .proc_pxl     (proc_pxl),
    .centroid     (centroid),
    .new_centroid (new_centroid),
    .proximity    (proximity),
    .rgbfilter    (rgbfilter)
  );

  // button order: none, red, green, blue, yellow, magenta, cyan, white
  function automatic filter_t filter_at(input int idx);
    case (idx)
      1:       return 3'b100;
      2:       return 3'b010;
      3:       return 3'b001;
      4:       return 3'b110;
      5:       return 3'b101;
      6:       return 3'b011;
      7:       return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  function automatic pixel_t scene_pixel(input pxl_addr_t a);
    int col;
    int row;
    col = int'(a) % img_cols;
    row = int'(a) / img_cols;
    if (col >= rect_c0 && col <= rect_c1 && row >= rect_r0 && row <= rect_r1)
      return rect_rgb;
    return bg_rgb;
  endfunction

  // pass when no filter or the three colour msbs equal the code, else black
  function automatic pixel_t expected_pixel(input pixel_t p, input filter_t f);
    filter_t msbs;
    msbs = {p[msb_red], p[msb_green], p[msb_blue]};
    return (f == 3'b000 || msbs == f) ? p : '0;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
  endtask

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %03h expected %03h", what, got, exp));
  endtask

  task automatic check_addr(input pxl_addr_t got, input pxl_addr_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_centroid(input centroid_t got, input centroid_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %02h expected %02h", what, got, exp));
  endtask

  task automatic check_prox(input prox_t got, input prox_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_filter(input filter_t got, input filter_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %03b expected %03b", what, got, exp));
  endtask

  task automatic check_gap(input int got, input int exp);
    if (got != exp)
      report_error($sformatf("new_centroid spacing got %0d cycles expected %0d", got, exp));
  endtask

  task automatic next_drive(input int n);
    repeat (n) @(posedge clk);
    #1;   // drive phase
  endtask

  task automatic press_button(input int n);
    repeat (n) begin
      proc_ctrl = 1'b1;
      next_drive(press_hold);
      proc_ctrl = 1'b0;
      next_drive(press_hold);
      filter_idx = (filter_idx + 1) % 8;
      exp_filter = filter_at(filter_idx);
      check_filter(rgbfilter, exp_filter, "rgbfilter after a press");
    end
  endtask

  task automatic wait_strobe();
    do @(negedge clk); while (new_centroid !== 1'b1);
  endtask

  task automatic load_trace();
    int fd;
    int n;
    int press, rgb, c0, c1, r0, r1;
    int bg, cent, prox;
    logic [8*160-1:0] line_buf;
    fd = $fopen("sim/color_trace.txt", "r");
    if (fd == 0)
      abort_run("could not open the trace file sim/color_trace.txt");
    while ($fgets(line_buf, fd) != 0) begin
      n = $sscanf(line_buf, "%d %h %d %d %d %d %h %h %d",
                  press, rgb, c0, c1, r0, r1, bg, cent, prox);
      if (n == 9) begin   // comment and blank lines do not parse
        t_press.push_back(press);
        t_rgb.push_back(pixel_t'(rgb));
        t_c0.push_back(c0);
        t_c1.push_back(c1);
        t_r0.push_back(r0);
        t_r1.push_back(r1);
        t_bg.push_back(pixel_t'(bg));
        t_cent.push_back(centroid_t'(cent));
        t_prox.push_back(prox);
      end
    end
    $fclose(fd);
    if (t_press.size() == 0)
      abort_run("the trace file holds no test lines");
    trace_ready = 1'b1;
  endtask

  // source memory, read latency of one cycle
  always @(posedge clk) begin
    rd_data = scene_pixel(orig_addr);
    #1;
    orig_pxl = rd_data;
  end

  // per cycle checks at the falling edge, where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      if (proc_we !== (cyc > 0))   // write enable from the first clock after reset
        report_error($sformatf("proc_we got %b at cycle %0d after reset", proc_we, cyc));
      if (proc_we) begin
        check_addr(proc_addr, exp_addr, "proc_addr");
        if (!settling)
          check_pixel(proc_pxl, expected_pixel(scene_pixel(exp_addr), exp_filter), "proc_pxl");
        exp_addr = (exp_addr == pxl_addr_t'(img_pxls - 1)) ? '0 : exp_addr + 1'b1;
      end
      check_addr(orig_addr, exp_addr, "orig_addr");   // read address runs one ahead
      if (new_centroid) begin
        if (last_strobe >= 0)
          check_gap(cyc - last_strobe, img_pxls);
        last_strobe = cyc;
      end
      cyc++;
    end
  end

  // three frames per trace line is more than any line needs
  initial begin
    wait (trace_ready);
    #(t_press.size() * 3.0 * img_pxls * clk_period + 10000.0);
    abort_run("timeout, the expected frame results did not arrive in time");
  end

  initial begin
    proc_ctrl = 1'b0;
    orig_pxl  = '0;
    load_trace();
    wait (rst === 1'b0);
    @(negedge clk);
    check_filter(rgbfilter, 3'b000, "rgbfilter after reset");
    check_centroid(centroid, '0, "centroid after reset");
    check_prox(proximity, '0, "proximity after reset");
    if (new_centroid !== 1'b0)
      report_error("new_centroid high after reset");
    for (int i = 0; i < t_press.size(); i++) begin
      next_drive(1);
      settling = 1'b1;
      rect_rgb = t_rgb[i];
      rect_c0  = t_c0[i];
      rect_c1  = t_c1[i];
      rect_r0  = t_r0[i];
      rect_r1  = t_r1[i];
      bg_rgb   = t_bg[i];
      press_button(t_press[i]);
      next_drive(4);
      check_filter(rgbfilter, exp_filter, $sformatf("rgbfilter, trace line %0d", i + 1));
      settling = 1'b0;
      wait_strobe();   // this frame straddled the change
      wait_strobe();
      check_centroid(centroid, t_cent[i], $sformatf("centroid, trace line %0d", i + 1));
      check_prox(proximity, prox_t'(t_prox[i]), $sformatf("proximity, trace line %0d", i + 1));
    end
    if (err_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("errors were counted during the run");
    end
  end

endmodule

//--- sim/color_trace.txt
// presses rect_rgb col_first col_last row_first row_last bg_rgb centroid proximity
// presses step the filter before the frame, centroid in hex, the rest decimal
0 0F0 20  30  20 30  000 18 7
1 F00 0   40  20 59  000 01 3
0 F00 100 159 0  119 777 40 6
5 0FF 60  99  30 69  800 18 4
0 0FF 60  103 30 69  800 10 4
0 0FF 70  79  50 59  000 00 0
1 FFF 40  75  10 49  777 04 4
0 FFF 64  87  8  111 777 08 5
1 00F 0   10  0  10  F00 18 7
1 F00 128 159 0  119 0F0 80 4

//--- filelist.f
verilog/color_pkg.sv
verilog/frame_scan.sv
verilog/color_decode.sv
verilog/histogram_acc.sv
verilog/centroid_result.sv
verilog/color_proc_top.sv
sim/tb_clock_gen.sv
sim/color_proc_tb.sv

//--- Bender.yml
package:
  name: color_proc

sources:
  - verilog/color_pkg.sv
  - verilog/frame_scan.sv
  - verilog/color_decode.sv
  - verilog/histogram_acc.sv
  - verilog/centroid_result.sv
  - verilog/color_proc_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/color_proc_tb.sv
